// ==== src.f ====
rtl/cart_mem_pkg.sv
rtl/mem_req_if.sv
rtl/snes_bus_sync.sv
rtl/mem_req_port.sv
rtl/mcu_mem_router.sv
rtl/rom_arbiter.sv
rtl/ram_arbiter.sv
rtl/cart_mem_top.sv
tests/cart_mem_chk.sv
tests/cart_mem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cart_mem_tb
FILELIST  ?= src.f
PASS_MSG  := Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== tests/cart_mem_tb.sv ====
`timescale 1ns/1ps

module cart_mem_tb;
  import cart_mem_pkg::*;

  // requests issued over all tests, each allowed 40 clocks
  localparam int REQ_COUNT  = 64;
  localparam int MAX_CYCLES = REQ_COUNT * 40 + 200;

  logic       CLK2 = 1'b0;
  logic       rst;
  logic       snes_cpu_clk = 1'b0;
  logic       snes_rd_n, snes_wr_n, snes_is_rom, snes_is_saveram;
  snes_addr_t snes_addr;
  logic       snes_rd_end, snes_wr_end, snes_cycle_start;
  logic       mcu_rrq, mcu_wrq, mcu_rdy;
  snes_addr_t mcu_addr;
  byte_t      mcu_wdata, mcu_rdata;
  logic       cop_rom_rrq, cop_rom_word, cop_rom_rdy;
  snes_addr_t cop_rom_addr, cop_ram_addr;
  word_t      cop_rom_rdata;
  logic       cop_ram_rrq, cop_ram_wrq, cop_ram_rdy, cop_rst;
  byte_t      cop_ram_wdata, cop_ram_rdata;
  rom_addr_t  rom_addr;
  word_t      rom_dq_in, rom_dq_out;
  logic       rom_dq_oe, rom_we_n, rom_bhe_n, rom_ble_n;
  ram_addr_t  ram_addr;
  byte_t      ram_dq_in, ram_dq_out;
  logic       ram_dq_oe, ram_we_n;

  word_t       rom_mem [0:4095];
  byte_t       ram_mem [0:4095];
  word_t       rom_shadow [0:4095];
  byte_t       ram_shadow [0:4095];
  snes_addr_t  addr_list [0:7];
  logic [15:0] lfsr;
  logic        cpu_run;
  logic [2:0]  cpu_div = 3'd0;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          revive_cnt = 0;

  cart_mem_top cart_mem_top_inst (.*);

  always #2 CLK2 = ~CLK2;

  // --------------------
  // memory models
  // --------------------

  assign rom_dq_in = rom_mem[rom_addr[11:0]];
  assign ram_dq_in = ram_mem[ram_addr[11:0]];

  always @(posedge CLK2) begin
    if (!rom_we_n && !rom_bhe_n)
      rom_mem[rom_addr[11:0]][15:8] <= rom_dq_out[15:8];
    if (!rom_we_n && !rom_ble_n)
      rom_mem[rom_addr[11:0]][7:0] <= rom_dq_out[7:0];
    if (!ram_we_n)
      ram_mem[ram_addr[11:0]] <= ram_dq_out;
  end

  function automatic word_t rom_fill(input logic [11:0] idx);
    return {idx[7:0] ^ 8'ha5, idx[11:4] + 8'h3c};
  endfunction

  function automatic byte_t ram_fill(input logic [11:0] idx);
    return idx[7:0] ^ {idx[11:8], idx[11:8]} ^ 8'h96;
  endfunction

  // SNES CPU clock, 12 CLK2 periods once running
  always @(posedge CLK2) begin
    #0.5;
    if (cpu_run) begin
      cpu_div = (cpu_div == 3'd5) ? 3'd0 : cpu_div + 3'd1;
      if (cpu_div == 3'd0)
        snes_cpu_clk = ~snes_cpu_clk;
    end
  end

  always @(posedge CLK2) begin
    if (cop_rst)
      revive_cnt <= revive_cnt + 1;
  end

  always @(posedge CLK2) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d clocks, a request never completed", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  // --------------------
  // reference model
  // --------------------

  // galois lfsr, one step per bit
  function automatic logic [23:0] rand_bits(input int n);
    logic [23:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
      val = {val[22:0], lfsr[0]};
    end
    return val;
  endfunction

  // odd byte on the low lane
  function automatic byte_t rom_byte(input snes_addr_t a);
    word_t w;
    w = rom_shadow[a[12:1]];
    return a[0] ? w[7:0] : w[15:8];
  endfunction

  function automatic byte_t expect_mcu(input snes_addr_t a);
    if (a[23:19] == RAM_WINDOW)
      return ram_shadow[a[11:0]];
    return rom_byte(a);
  endfunction

  task automatic store_byte(input snes_addr_t a, input byte_t d);
    if (a[23:19] == RAM_WINDOW)
      ram_shadow[a[11:0]] = d;
    else if (a[0])
      rom_shadow[a[12:1]][7:0] = d;
    else
      rom_shadow[a[12:1]][15:8] = d;
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    checks++;
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    if (errors == err_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - err_before);
  endtask

  // --------------------
  // requests
  // --------------------

  // data buses driven only while the write strobe is low
  task automatic step_clock();
    @(posedge CLK2);
    #0.5;
    check_bit("rom_dq_oe", rom_dq_oe, !rom_we_n);
    check_bit("ram_dq_oe", ram_dq_oe, !ram_we_n);
  endtask

  task automatic mcu_write(input snes_addr_t a, input byte_t d);
    mcu_addr  = a;
    mcu_wdata = d;
    mcu_wrq   = 1'b1;
    step_clock();
    mcu_wrq = 1'b0;
    while (!mcu_rdy)
      step_clock();
    store_byte(a, d);
  endtask

  task automatic mcu_read(input snes_addr_t a);
    mcu_addr = a;
    mcu_rrq  = 1'b1;
    step_clock();
    mcu_rrq = 1'b0;
    while (!mcu_rdy)
      step_clock();
    check_byte("mcu_rdata", mcu_rdata, expect_mcu(a));
  endtask

  task automatic cop_rom_read(input snes_addr_t a, input logic word);
    cop_rom_addr = a;
    cop_rom_word = word;
    cop_rom_rrq  = 1'b1;
    step_clock();
    cop_rom_rrq = 1'b0;
    while (!cop_rom_rdy)
      step_clock();
    // low byte is always the addressed one
    if (word)
      check_word("cop_rom_rdata", cop_rom_rdata, {rom_byte(a ^ 24'd1), rom_byte(a)});
    else
      check_byte("cop_rom_rdata", cop_rom_rdata[7:0], rom_byte(a));
  endtask

  task automatic cop_ram_access(input snes_addr_t a, input logic wr, input byte_t d);
    cop_ram_addr  = a;
    cop_ram_wdata = d;
    cop_ram_wrq   = wr;
    cop_ram_rrq   = ~wr;
    step_clock();
    cop_ram_wrq = 1'b0;
    cop_ram_rrq = 1'b0;
    while (!cop_ram_rdy)
      step_clock();
    if (wr)
      ram_shadow[a[11:0]] = d;
    else
      check_byte("cop_ram_rdata", cop_ram_rdata, ram_shadow[a[11:0]]);
  endtask

  // MCU and coprocessor read in the same cycle
  task automatic race_reads(input logic to_ram, input snes_addr_t ma, input snes_addr_t ca);
    int n;
    int cop_at;
    int mcu_at;
    mcu_addr     = ma;
    mcu_rrq      = 1'b1;
    cop_rom_addr = ca;
    cop_ram_addr = ca;
    cop_rom_word = 1'b1;
    cop_rom_rrq  = ~to_ram;
    cop_ram_rrq  = to_ram;
    step_clock();
    mcu_rrq     = 1'b0;
    cop_rom_rrq = 1'b0;
    cop_ram_rrq = 1'b0;
    n      = 0;
    cop_at = -1;
    mcu_at = -1;
    while (cop_at < 0 || mcu_at < 0) begin
      if (cop_at < 0 && (to_ram ? cop_ram_rdy : cop_rom_rdy))
        cop_at = n;
      if (mcu_at < 0 && mcu_rdy)
        mcu_at = n;
      step_clock();
      n++;
    end
    check_byte("mcu_rdata", mcu_rdata, expect_mcu(ma));
    if (to_ram)
      check_byte("cop_ram_rdata", cop_ram_rdata, ram_shadow[ca[11:0]]);
    else
      check_word("cop_rom_rdata", cop_rom_rdata, {rom_byte(ca ^ 24'd1), rom_byte(ca)});
    if (cop_at > mcu_at) begin
      $display("coprocessor became ready %0d clocks after the MCU", cop_at - mcu_at);
      errors++;
    end
  endtask

  // one SNES strobe low for six clocks, then count the end pulses
  task automatic pulse_strobe(input logic wr);
    int rd_ends;
    int wr_ends;
    rd_ends = 0;
    wr_ends = 0;
    snes_rd_n = wr;
    snes_wr_n = ~wr;
    for (int i = 0; i < 16; i++) begin
      step_clock();
      if (snes_rd_end)
        rd_ends++;
      if (snes_wr_end)
        wr_ends++;
      if (i == 5) begin
        snes_rd_n = 1'b1;
        snes_wr_n = 1'b1;
      end
    end
    if (rd_ends != (wr ? 0 : 1) || wr_ends != (wr ? 1 : 0)) begin
      $display("%0d read end and %0d write end pulses after one %s strobe",
               rd_ends, wr_ends, wr ? "write" : "read");
      errors++;
    end
  endtask

  // --------------------
  // test sequence
  // --------------------

  initial begin
    int err0;
    int starts;
    snes_addr_t a;
    rst = 1'b1;
    snes_rd_n = 1'b1;
    snes_wr_n = 1'b1;
    snes_addr = '0;
    snes_is_rom = 1'b0;
    snes_is_saveram = 1'b0;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    mcu_addr = '0;
    mcu_wdata = '0;
    cop_rom_rrq = 1'b0;
    cop_rom_word = 1'b0;
    cop_rom_addr = '0;
    cop_ram_rrq = 1'b0;
    cop_ram_wrq = 1'b0;
    cop_ram_addr = '0;
    cop_ram_wdata = '0;
    cpu_run = 1'b0;
    lfsr = 16'd2;
    for (int i = 0; i < 4096; i++) begin
      rom_mem[i]    = rom_fill(12'(i));
      rom_shadow[i] = rom_fill(12'(i));
      ram_mem[i]    = ram_fill(12'(i));
      ram_shadow[i] = ram_fill(12'(i));
    end
    repeat (4) @(posedge CLK2);
    #0.5 rst = 1'b0;
    step_clock();
    if (!mcu_rdy || !cop_rom_rdy || !cop_ram_rdy || !rom_we_n || !ram_we_n ||
        rom_dq_oe || ram_dq_oe) begin
      $display("ready, write strobe or output enable not idle after reset");
      errors++;
    end

    // console dead, ROM through both lanes
    err0 = errors;
    for (int i = 0; i < 8; i++) begin
      addr_list[i] = {1'b0, 22'(rand_bits(22)), i[0]};
      mcu_write(addr_list[i], byte_t'(rand_bits(8)));
    end
    for (int i = 0; i < 8; i++)
      mcu_read(addr_list[i]);
    report_test("dead_console_rom", err0);

    err0 = errors;
    for (int i = 0; i < 6; i++) begin
      addr_list[i] = {RAM_WINDOW, 19'(rand_bits(19))};
      mcu_write(addr_list[i], byte_t'(rand_bits(8)));
    end
    for (int i = 0; i < 6; i++)
      mcu_read(addr_list[i]);
    for (int i = 0; i < 4096; i++)
      check_word("rom_mem", rom_mem[i], rom_shadow[i]);
    report_test("saveram_window", err0);

    err0 = errors;
    for (int i = 0; i < 8; i++) begin
      a = {1'b0, 22'(rand_bits(22)), i[1]};
      cop_rom_read(a, i[0]);
    end
    report_test("cop_rom_read", err0);

    err0 = errors;
    for (int i = 0; i < 6; i++) begin
      addr_list[i] = rand_bits(24);
      cop_ram_access(addr_list[i], 1'b1, byte_t'(rand_bits(8)));
    end
    for (int i = 0; i < 6; i++)
      cop_ram_access(addr_list[i], 1'b0, 8'h00);
    report_test("cop_ram", err0);

    err0 = errors;
    for (int i = 0; i < 2; i++) begin
      race_reads(1'b0, {1'b0, 23'(rand_bits(23))}, {1'b0, 23'(rand_bits(23))});
      race_reads(1'b1, {RAM_WINDOW, 19'(rand_bits(19))}, rand_bits(24));
    end
    report_test("priority", err0);

    // CPU clock returns with the SNES on ROM
    err0 = errors;
    snes_is_rom = 1'b1;
    snes_addr   = 24'h008000;
    cpu_run     = 1'b1;
    for (int i = 0; i < 4; i++) begin
      a = {1'b0, 22'(rand_bits(22)), i[0]};
      mcu_write(a, byte_t'(rand_bits(8)));
      mcu_read(a);
    end
    repeat (24) step_clock();
    if (revive_cnt != 1) begin
      $display("cop_rst pulsed %0d times after the CPU clock started, expected once", revive_cnt);
      errors++;
    end
    report_test("revive_snes_active", err0);

    // one cycle start per rising CPU clock, one end per strobe
    err0 = errors;
    @(posedge snes_cpu_clk);
    starts = 0;
    repeat (8) begin
      step_clock();
      if (snes_cycle_start)
        starts++;
    end
    if (starts != 1) begin
      $display("cycle start pulsed %0d times after a CPU clock rise, expected once", starts);
      errors++;
    end
    pulse_strobe(1'b0);
    pulse_strobe(1'b1);
    report_test("snes_strobes", err0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== tests/cart_mem_chk.sv ====
`timescale 1ns/1ps

module cart_mem_chk (
  input logic       CLK2,
  input logic       rst,
  input logic       abort,
  input logic       in_access,
  input logic       wr_state,
  input logic       we_n,
  input logic       mcu_done,
  input logic       cop_done,
  input logic [3:0] cyc_len
);

  logic [4:0] acc_cnt = 5'd0;

  // clocks spent in the current access state
  always @(posedge CLK2) begin
    if (rst || !in_access)
      acc_cnt <= 5'd0;
    else
      acc_cnt <= acc_cnt + 5'd1;
  end

  // strobe only while a pending write is being served
  we_in_write: assert property (@(posedge CLK2) disable iff (rst) !we_n |-> wr_state)
    else $error("write strobe low outside a write state");

  mcu_done_pulse: assert property (@(posedge CLK2) disable iff (rst) mcu_done |=> !mcu_done)
    else $error("mcu done longer than one clock");

  cop_done_pulse: assert property (@(posedge CLK2) disable iff (rst) cop_done |=> !cop_done)
    else $error("cop done longer than one clock");

  // an abort ends the access early
  access_holds: assert property (@(posedge CLK2) disable iff (rst || abort)
    in_access && (acc_cnt < {1'b0, cyc_len}) |=> in_access)
    else $error("access state left too early");

  access_ends: assert property (@(posedge CLK2) disable iff (rst || abort)
    in_access && (acc_cnt == {1'b0, cyc_len}) |=> !in_access)
    else $error("access state held too long");

endmodule

bind rom_arbiter cart_mem_chk rom_chk_inst (
  .CLK2 (CLK2), .rst (rst), .abort (abort), .in_access (cop_hit | mcu_hit),
  .wr_state ((mcu_hit & mcu.pend_wr) | (cop_hit & cop.pend_wr)), .we_n (rom_we_n),
  .mcu_done (mcu.done), .cop_done (cop.done), .cyc_len (cart_mem_pkg::ROM_CYCLE_LEN)
);

bind ram_arbiter cart_mem_chk ram_chk_inst (
  .CLK2 (CLK2), .rst (rst), .abort (abort), .in_access (cop_hit | mcu_hit),
  .wr_state ((mcu_hit & mcu.pend_wr) | (cop_hit & cop.pend_wr)),
  .we_n (ram_we_n), .mcu_done (mcu.done), .cop_done (cop.done),
  .cyc_len (cart_mem_pkg::RAM_CYCLE_LEN)
);

// ==== rtl/cart_mem_top.sv ====
`timescale 1ns/1ps

module cart_mem_top (
  input  logic        CLK2,
  input  logic        rst,
  // SNES side, address already mapped
  input  logic        snes_cpu_clk,
  input  logic        snes_rd_n,
  input  logic        snes_wr_n,
  input  logic [23:0] snes_addr,
  input  logic        snes_is_rom,
  input  logic        snes_is_saveram,
  output logic        snes_rd_end,
  output logic        snes_wr_end,
  output logic        snes_cycle_start,
  // MCU
  input  logic        mcu_rrq,
  input  logic        mcu_wrq,
  input  logic [23:0] mcu_addr,
  input  logic [7:0]  mcu_wdata,
  output logic [7:0]  mcu_rdata,
  output logic        mcu_rdy,
  // coprocessor
  input  logic        cop_rom_rrq,
  input  logic        cop_rom_word,
  input  logic [23:0] cop_rom_addr,
  output logic [15:0] cop_rom_rdata,
  output logic        cop_rom_rdy,
  input  logic        cop_ram_rrq,
  input  logic        cop_ram_wrq,
  input  logic [23:0] cop_ram_addr,
  input  logic [7:0]  cop_ram_wdata,
  output logic [7:0]  cop_ram_rdata,
  output logic        cop_ram_rdy,
  output logic        cop_rst,
  // ROM PSRAM
  output logic [22:0] rom_addr,
  input  logic [15:0] rom_dq_in,
  output logic [15:0] rom_dq_out,
  output logic        rom_dq_oe,
  output logic        rom_we_n,
  output logic        rom_bhe_n,
  output logic        rom_ble_n,
  // save SRAM
  output logic [18:0] ram_addr,
  input  logic [7:0]  ram_dq_in,
  output logic [7:0]  ram_dq_out,
  output logic        ram_dq_oe,
  output logic        ram_we_n
);

  logic cycle_end;
  logic cpu_clk_now;
  logic dead;

  mem_req_if #(.DATA_W(16)) mcu_rom_if ();
  mem_req_if #(.DATA_W(8))  mcu_ram_if ();
  mem_req_if #(.DATA_W(16)) cop_rom_if ();
  mem_req_if #(.DATA_W(8))  cop_ram_if ();

  snes_bus_sync snes_bus_sync_inst (
    .CLK2 (CLK2), .rst (rst), .snes_cpu_clk (snes_cpu_clk),
    .snes_rd_n (snes_rd_n), .snes_wr_n (snes_wr_n),
    .rd_end (snes_rd_end), .wr_end (snes_wr_end),
    .cycle_start (snes_cycle_start), .cycle_end (cycle_end),
    .cpu_clk_now (cpu_clk_now), .dead (dead), .revive (cop_rst)
  );

  mcu_mem_router mcu_mem_router_inst (
    .CLK2 (CLK2), .rst (rst), .mcu_rrq (mcu_rrq), .mcu_wrq (mcu_wrq),
    .mcu_addr (mcu_addr), .mcu_wdata (mcu_wdata), .mcu_rdata (mcu_rdata),
    .mcu_rdy (mcu_rdy), .rom (mcu_rom_if), .ram (mcu_ram_if)
  );

  // coprocessor only reads ROM
  mem_req_port #(.DATA_W(16)) cop_rom_port_inst (
    .CLK2 (CLK2), .rst (rst), .rrq (cop_rom_rrq), .wrq (1'b0),
    .word (cop_rom_word), .addr (cop_rom_addr), .wdata (16'h0000),
    .rdy (cop_rom_rdy), .mem (cop_rom_if)
  );

  mem_req_port #(.DATA_W(8)) cop_ram_port_inst (
    .CLK2 (CLK2), .rst (rst), .rrq (cop_ram_rrq), .wrq (cop_ram_wrq),
    .word (1'b0), .addr (cop_ram_addr), .wdata (cop_ram_wdata),
    .rdy (cop_ram_rdy), .mem (cop_ram_if)
  );

  assign cop_rom_rdata = cop_rom_if.rdata;
  assign cop_ram_rdata = cop_ram_if.rdata;

  rom_arbiter rom_arbiter_inst (
    .CLK2 (CLK2), .rst (rst), .cycle_end (cycle_end), .dead (dead),
    .cpu_clk_now (cpu_clk_now), .snes_is_rom (snes_is_rom), .snes_addr (snes_addr),
    .mcu (mcu_rom_if), .cop (cop_rom_if), .rom_addr (rom_addr),
    .rom_dq_in (rom_dq_in), .rom_dq_out (rom_dq_out), .rom_dq_oe (rom_dq_oe),
    .rom_we_n (rom_we_n), .rom_bhe_n (rom_bhe_n), .rom_ble_n (rom_ble_n)
  );

  ram_arbiter ram_arbiter_inst (
    .CLK2 (CLK2), .rst (rst), .cycle_end (cycle_end), .dead (dead),
    .cpu_clk_now (cpu_clk_now), .snes_is_saveram (snes_is_saveram),
    .snes_addr (snes_addr), .mcu (mcu_ram_if), .cop (cop_ram_if),
    .ram_addr (ram_addr), .ram_dq_in (ram_dq_in), .ram_dq_out (ram_dq_out),
    .ram_dq_oe (ram_dq_oe), .ram_we_n (ram_we_n)
  );

endmodule

// ==== rtl/ram_arbiter.sv ====
`timescale 1ns/1ps

module ram_arbiter (
  input  logic                     CLK2,
  input  logic                     rst,
  input  logic                     cycle_end,
  input  logic                     dead,
  input  logic                     cpu_clk_now,
  input  logic                     snes_is_saveram,
  input  cart_mem_pkg::snes_addr_t snes_addr,
  mem_req_if.server                mcu,
  mem_req_if.server                cop,
  output cart_mem_pkg::ram_addr_t  ram_addr,
  input  cart_mem_pkg::byte_t      ram_dq_in,
  output cart_mem_pkg::byte_t      ram_dq_out,
  output logic                     ram_dq_oe,
  output logic                     ram_we_n
);
  import cart_mem_pkg::*;

  ram_state_t state;
  logic [3:0] delay;
  logic       cop_owner;
  logic       free_slot;
  logic       abort;
  logic       cop_hit;
  logic       mcu_hit;
  logic       wr_hit;

  assign free_slot = cycle_end | ~snes_is_saveram | dead;
  assign abort     = dead & cpu_clk_now;
  assign cop_hit   = (state == RAM_COP_RD) || (state == RAM_COP_WR);
  assign mcu_hit   = (state == RAM_MCU_RD) || (state == RAM_MCU_WR);
  assign wr_hit    = (state == RAM_COP_WR) || (state == RAM_MCU_WR);

  // --------------------
  // state machine
  // --------------------

  always_ff @(posedge CLK2) begin
    if (rst) begin
      state     <= RAM_IDLE;
      delay     <= '0;
      cop_owner <= 1'b0;
    end else if (abort) begin
      state <= RAM_IDLE;
    end else begin
      case (state)
        RAM_IDLE: begin
          if (free_slot) begin
            delay <= RAM_CYCLE_LEN;
            if (cop.pend_rd | cop.rrq) begin
              state     <= RAM_COP_RD;
              cop_owner <= 1'b1;
            end else if (cop.pend_wr | cop.wrq) begin
              state     <= RAM_COP_WR;
              cop_owner <= 1'b1;
            end else if (mcu.pend_rd) begin
              state     <= RAM_MCU_RD;
              cop_owner <= 1'b0;
            end else if (mcu.pend_wr) begin
              state     <= RAM_MCU_WR;
              cop_owner <= 1'b0;
            end
          end
        end
        RAM_MCU_RD, RAM_MCU_WR, RAM_COP_RD, RAM_COP_WR: begin
          delay <= delay - 4'd1;
          if (delay == 4'd0) begin
            state <= RAM_DONE;
          end
        end
        default: state <= RAM_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK2) begin
    if (state == RAM_MCU_RD) begin
      mcu.rdata <= ram_dq_in;
    end
    if (state == RAM_COP_RD) begin
      cop.rdata <= ram_dq_in;
    end
  end

  // both requesters released in DONE
  assign mcu.done = (state == RAM_DONE) && !cop_owner;
  assign cop.done = (state == RAM_DONE) && cop_owner;

  // --------------------
  // memory pins
  // --------------------

  always_comb begin
    if (cop_hit) begin
      ram_addr = cop.addr[18:0];
    end else if (mcu_hit) begin
      ram_addr = mcu.addr[18:0];
    end else begin
      ram_addr = snes_addr[18:0];
    end
  end

  // strobe held low for the whole write access
  assign ram_we_n   = ~wr_hit;
  assign ram_dq_oe  = wr_hit;
  assign ram_dq_out = (state == RAM_COP_WR) ? cop.wdata : mcu.wdata;

endmodule

// ==== rtl/rom_arbiter.sv ====
`timescale 1ns/1ps

module rom_arbiter (
  input  logic                     CLK2,
  input  logic                     rst,
  input  logic                     cycle_end,
  input  logic                     dead,
  input  logic                     cpu_clk_now,
  input  logic                     snes_is_rom,
  input  cart_mem_pkg::snes_addr_t snes_addr,
  mem_req_if.server                mcu,
  mem_req_if.server                cop,
  output cart_mem_pkg::rom_addr_t  rom_addr,
  input  cart_mem_pkg::word_t      rom_dq_in,
  output cart_mem_pkg::word_t      rom_dq_out,
  output logic                     rom_dq_oe,
  output logic                     rom_we_n,
  output logic                     rom_bhe_n,
  output logic                     rom_ble_n
);
  import cart_mem_pkg::*;

  rom_state_t state;
  logic [3:0] delay;
  logic       cop_owner;
  logic       free_slot;
  logic       abort;
  logic       cop_hit;
  logic       mcu_hit;
  logic       both_lanes;
  snes_addr_t cur_addr;

  assign free_slot = cycle_end | ~snes_is_rom | dead;
  // console waking up cancels the access in flight
  assign abort     = dead & cpu_clk_now;
  assign cop_hit   = (state == ROM_COP_RD);
  assign mcu_hit   = (state == ROM_MCU_RD) || (state == ROM_MCU_WR);

  // --------------------
  // state machine
  // --------------------

  always_ff @(posedge CLK2) begin
    if (rst) begin
      state     <= ROM_IDLE;
      delay     <= '0;
      cop_owner <= 1'b0;
    end else if (abort) begin
      state <= ROM_IDLE;
    end else begin
      case (state)
        ROM_IDLE: begin
          if (free_slot) begin
            // coprocessor request is taken in the same clock it arrives
            if (cop.pend_rd | cop.rrq) begin
              state     <= ROM_COP_RD;
              delay     <= ROM_CYCLE_LEN;
              cop_owner <= 1'b1;
            end else if (mcu.pend_rd) begin
              state     <= ROM_MCU_RD;
              delay     <= ROM_CYCLE_LEN;
              cop_owner <= 1'b0;
            end else if (mcu.pend_wr) begin
              state     <= ROM_MCU_WR;
              delay     <= ROM_CYCLE_LEN;
              cop_owner <= 1'b0;
            end
          end
        end
        ROM_MCU_RD, ROM_MCU_WR, ROM_COP_RD: begin
          delay <= delay - 4'd1;
          if (delay == 4'd0) begin
            state <= ROM_DONE;
          end
        end
        // DONE lasts one clock
        default: state <= ROM_IDLE;
      endcase
    end
  end

  // last sample of the access state is the one that counts
  always_ff @(posedge CLK2) begin
    if (state == ROM_MCU_RD) begin
      mcu.rdata <= rom_dq_in;
    end
    if (cop_hit) begin
      cop.rdata <= cop.addr[0] ? rom_dq_in : {rom_dq_in[7:0], rom_dq_in[15:8]};
    end
  end

  // coprocessor released one clock early
  assign cop.done = cop_hit && (delay == 4'd0) && !abort;
  assign mcu.done = (state == ROM_DONE) && !cop_owner;

  // --------------------
  // memory pins
  // --------------------

  always_comb begin
    if (cop_hit) begin
      cur_addr = cop.addr;
    end else if (mcu_hit) begin
      cur_addr = mcu.addr;
    end else begin
      cur_addr = snes_addr;
    end
  end

  assign both_lanes = cop_hit & cop.word;
  assign rom_addr   = cur_addr[23:1];
  assign rom_ble_n  = ~cur_addr[0] & ~both_lanes;
  assign rom_bhe_n  = cur_addr[0] & ~both_lanes;
  assign rom_we_n   = (state != ROM_MCU_WR);
  assign rom_dq_oe  = (state == ROM_MCU_WR);
  assign rom_dq_out = mcu.wdata;

endmodule

// ==== rtl/mcu_mem_router.sv ====
`timescale 1ns/1ps

module mcu_mem_router (
  input  logic                     CLK2,
  input  logic                     rst,
  input  logic                     mcu_rrq,
  input  logic                     mcu_wrq,
  input  cart_mem_pkg::snes_addr_t mcu_addr,
  input  cart_mem_pkg::byte_t      mcu_wdata,
  output cart_mem_pkg::byte_t      mcu_rdata,
  output logic                     mcu_rdy,
  mem_req_if.requester             rom,
  mem_req_if.requester             ram
);
  import cart_mem_pkg::*;

  logic  ram_sel;
  logic  rom_rdy;
  logic  ram_rdy;
  byte_t rom_byte;

  assign ram_sel = (mcu_addr[23:19] == RAM_WINDOW);

  // byte written on both lanes, the arbiter enables only one
  mem_req_port #(.DATA_W(16)) rom_port_inst (
    .CLK2  (CLK2),
    .rst   (rst),
    .rrq   (mcu_rrq & ~ram_sel),
    .wrq   (mcu_wrq & ~ram_sel),
    .word  (1'b0),
    .addr  (mcu_addr),
    .wdata ({mcu_wdata, mcu_wdata}),
    .rdy   (rom_rdy),
    .mem   (rom)
  );

  mem_req_port #(.DATA_W(8)) ram_port_inst (
    .CLK2  (CLK2),
    .rst   (rst),
    .rrq   (mcu_rrq & ram_sel),
    .wrq   (mcu_wrq & ram_sel),
    .word  (1'b0),
    .addr  (mcu_addr),
    .wdata (mcu_wdata),
    .rdy   (ram_rdy),
    .mem   (ram)
  );

  // odd byte on the low lane
  assign rom_byte = rom.addr[0] ? rom.rdata[7:0] : rom.rdata[15:8];

  always_ff @(posedge CLK2) begin
    if (rom.done && rom.pend_rd) begin
      mcu_rdata <= rom_byte;
    end else if (ram.done && ram.pend_rd) begin
      mcu_rdata <= ram.rdata;
    end
  end

  assign mcu_rdy = rom_rdy & ram_rdy;

endmodule

// ==== rtl/mem_req_port.sv ====
`timescale 1ns/1ps

module mem_req_port #(
  parameter int DATA_W = 8
) (
  input  logic                     CLK2,
  input  logic                     rst,
  input  logic                     rrq,
  input  logic                     wrq,
  input  logic                     word,
  input  cart_mem_pkg::snes_addr_t addr,
  input  logic [DATA_W-1:0]        wdata,
  output logic                     rdy,
  mem_req_if.requester             mem
);
  import cart_mem_pkg::*;

  logic              pend_rd_q;
  logic              pend_wr_q;
  logic              rd_take;
  logic              wr_take;
  snes_addr_t        addr_q;
  logic              word_q;
  logic [DATA_W-1:0] wdata_q;

  assign rdy = ~(pend_rd_q | pend_wr_q);

  // read wins over a write in the same cycle
  assign rd_take = rrq & rdy;
  assign wr_take = wrq & ~rrq & rdy;

  // pending flags held until the arbiter reports done
  always_ff @(posedge CLK2) begin
    if (rst) begin
      pend_rd_q <= 1'b0;
      pend_wr_q <= 1'b0;
    end else if (rd_take) begin
      pend_rd_q <= 1'b1;
    end else if (wr_take) begin
      pend_wr_q <= 1'b1;
    end else if (mem.done) begin
      pend_rd_q <= 1'b0;
      pend_wr_q <= 1'b0;
    end
  end

  always_ff @(posedge CLK2) begin
    if (rd_take | wr_take) begin
      addr_q <= addr;
      word_q <= word;
    end
    if (wr_take) begin
      wdata_q <= wdata;
    end
  end

  // live request goes along so the arbiter can grant a clock early
  assign mem.rrq     = rd_take;
  assign mem.wrq     = wr_take;
  assign mem.addr    = addr_q;
  assign mem.word    = word_q;
  assign mem.wdata   = wdata_q;
  assign mem.pend_rd = pend_rd_q;
  assign mem.pend_wr = pend_wr_q;

endmodule

// ==== rtl/snes_bus_sync.sv ====
`timescale 1ns/1ps

module snes_bus_sync (
  input  logic CLK2,
  input  logic rst,
  input  logic snes_cpu_clk,
  input  logic snes_rd_n,
  input  logic snes_wr_n,
  output logic rd_end,
  output logic wr_end,
  output logic cycle_start,
  output logic cycle_end,
  output logic cpu_clk_now,
  output logic dead,
  output logic revive
);
  import cart_mem_pkg::*;

  logic [SYNC_DEPTH-1:0] rd_sr;
  logic [SYNC_DEPTH-1:0] wr_sr;
  logic [SYNC_DEPTH-1:0] clk_sr;
  logic [17:0]           dead_cnt;

  // --------------------
  // input sampling
  // --------------------

  // newest sample enters at bit 0
  always_ff @(posedge CLK2) begin
    if (rst) begin
      rd_sr  <= '1;
      wr_sr  <= '1;
      clk_sr <= '0;
    end else begin
      rd_sr  <= {rd_sr[SYNC_DEPTH-2:0], snes_rd_n};
      wr_sr  <= {wr_sr[SYNC_DEPTH-2:0], snes_wr_n};
      clk_sr <= {clk_sr[SYNC_DEPTH-2:0], snes_cpu_clk};
    end
  end

  // strobe released after a clean low stretch
  always_ff @(posedge CLK2) begin
    if (rst) begin
      rd_end <= 1'b0;
      wr_end <= 1'b0;
    end else begin
      rd_end <= ((rd_sr[5:0] & rd_sr[6:1]) == 6'b000001);
      wr_end <= ((wr_sr[5:0] & wr_sr[6:1]) == 6'b000001);
    end
  end

  // rising and falling windows of the CPU clock
  assign cycle_start = ((clk_sr[7:2] & clk_sr[6:1]) == 6'b000011);
  assign cycle_end   = ((clk_sr[7:2] | clk_sr[6:1]) == 6'b111000);
  assign cpu_clk_now = clk_sr[2] & clk_sr[1];

  // --------------------
  // dead console detect
  // --------------------

  always_ff @(posedge CLK2) begin
    if (rst) begin
      dead_cnt <= '0;
      dead     <= 1'b1;
      revive   <= 1'b0;
    end else if (cpu_clk_now) begin
      dead_cnt <= '0;
      dead     <= 1'b0;
      // first high clock after a dead phase
      revive   <= dead;
    end else begin
      revive <= 1'b0;
      if (!dead) begin
        dead_cnt <= dead_cnt + 18'd1;
      end
      if (dead_cnt > DEAD_TIMEOUT) begin
        dead <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if #(
  parameter int DATA_W = 8
);
  import cart_mem_pkg::*;

  // request side
  logic              rrq;
  logic              wrq;
  logic              word;
  snes_addr_t        addr;
  logic [DATA_W-1:0] wdata;
  logic              pend_rd;
  logic              pend_wr;

  // arbiter side
  logic [DATA_W-1:0] rdata;
  logic              done;

  modport requester (
    output rrq, wrq, word, addr, wdata, pend_rd, pend_wr,
    input  rdata, done
  );

  modport server (
    input  rrq, wrq, word, addr, wdata, pend_rd, pend_wr,
    output rdata, done
  );

endinterface

// ==== rtl/cart_mem_pkg.sv ====
package cart_mem_pkg;

  // --------------------
  // bus widths
  // --------------------

  // SNES and MCU side byte address
  typedef logic [23:0] snes_addr_t;

  // PSRAM word address, bit 0 of the byte address picks the lane
  typedef logic [22:0] rom_addr_t;

  // save SRAM byte address
  typedef logic [18:0] ram_addr_t;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] word_t;

  // --------------------
  // memory map and timing
  // --------------------

  // address bits 23..19 of the save-RAM window seen by the MCU
  localparam logic [4:0] RAM_WINDOW = 5'b11100;

  // access state lasts LEN+1 clocks
  localparam logic [3:0] ROM_CYCLE_LEN = 4'd7;
  localparam logic [3:0] RAM_CYCLE_LEN = 4'd5;

  // clocks of CPU clock low before the console counts as dead
  localparam logic [17:0] DEAD_TIMEOUT = 18'd64;

  // stages per strobe shift register
  localparam int SYNC_DEPTH = 8;

  // --------------------
  // arbiter states
  // --------------------

  typedef enum logic [2:0] {
    ROM_IDLE, ROM_MCU_RD, ROM_MCU_WR, ROM_COP_RD, ROM_DONE
  } rom_state_t;

  typedef enum logic [2:0] {
    RAM_IDLE, RAM_MCU_RD, RAM_MCU_WR, RAM_COP_RD, RAM_COP_WR, RAM_DONE
  } ram_state_t;

endpackage
